/* rtl/mips_pkg.sv */
package mips_pkg;

    // ##############################
    // widths fixed by the encoding
    // ##############################

    localparam int INST_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // ##############################
    // instruction fields
    // ##############################

    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110,
        OP_LUI      = 6'b001111,
        OP_SPECIAL2 = 6'b011100,  // mul and count ops live here, decoded as nop
        OP_PREF     = 6'b110011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_SYNC = 6'b001111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // ##############################
    // execute stage control
    // ##############################

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_AND  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_ADD  = 4'd8,  // add and addu both wrap
        ALU_SUB  = 4'd9,
        ALU_SLT  = 4'd10,
        ALU_SLTU = 4'd11,
        ALU_MOV  = 4'd12
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NONE  = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MOVE  = 3'd4
    } alu_sel_e;

endpackage

/* rtl/id_decode.sv */
`timescale 1ns/1ps

module id_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mips_pkg::INST_WIDTH-1:0]     inst_data,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     rd_data1,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     rd_data2,
    input  logic                                ex_wen,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     ex_wdata,
    input  logic                                wb_en,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     wb_data,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr1,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr2,
    output mips_pkg::alu_op_e                   ex_op,
    output mips_pkg::alu_sel_e                  ex_sel,
    output logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd1,
    output logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd2,
    output logic                                ex_wreg,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr_d
);

    // ##############################
    // field split
    // ##############################

    mips_pkg::opcode_e                   opcode;
    mips_pkg::funct_e                    funct;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] rs;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] rt;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] shamt;
    logic [15:0]                         imm;

    assign opcode = mips_pkg::opcode_e'(inst_data[31:26]);
    assign rs     = inst_data[25:21];
    assign rt     = inst_data[20:16];
    assign rd     = inst_data[15:11];
    assign shamt  = inst_data[10:6];
    assign funct  = mips_pkg::funct_e'(inst_data[5:0]);
    assign imm    = inst_data[15:0];

    // ##############################
    // control decode
    // ##############################

    mips_pkg::alu_op_e                   dec_op;
    logic                                rd_en1;
    logic                                rd_en2;
    logic                                dec_wen;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] dec_waddr;
    logic [mips_pkg::DATA_WIDTH-1:0]     imm_data;

    function automatic mips_pkg::alu_sel_e op_class(input mips_pkg::alu_op_e op);
        case (op)
            mips_pkg::ALU_AND, mips_pkg::ALU_OR,
            mips_pkg::ALU_XOR, mips_pkg::ALU_NOR:  return mips_pkg::SEL_LOGIC;
            mips_pkg::ALU_SLL, mips_pkg::ALU_SRL,
            mips_pkg::ALU_SRA:                     return mips_pkg::SEL_SHIFT;
            mips_pkg::ALU_ADD, mips_pkg::ALU_SUB,
            mips_pkg::ALU_SLT, mips_pkg::ALU_SLTU: return mips_pkg::SEL_ARITH;
            mips_pkg::ALU_MOV:                     return mips_pkg::SEL_MOVE;
            default:                               return mips_pkg::SEL_NONE;
        endcase
    endfunction

    always_comb begin
        dec_op    = mips_pkg::ALU_NOP;
        rd_en1    = 1'b0;
        rd_en2    = 1'b0;
        dec_wen   = 1'b0;
        dec_waddr = rt;  // i-type writes rt
        imm_data  = '0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dec_waddr = rd;
                rd_en1    = 1'b1;
                rd_en2    = 1'b1;
                dec_wen   = (shamt == '0);  // every r-type except constant shifts
                case (funct)
                    mips_pkg::FN_SLL, mips_pkg::FN_SLLV: dec_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL, mips_pkg::FN_SRLV: dec_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA, mips_pkg::FN_SRAV: dec_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_AND:                    dec_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:                     dec_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:                    dec_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:                    dec_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_ADD, mips_pkg::FN_ADDU: dec_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB, mips_pkg::FN_SUBU: dec_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_SLT:                    dec_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU:                   dec_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_MOVZ, mips_pkg::FN_MOVN: dec_op = mips_pkg::ALU_MOV;
                    default:                             dec_wen = 1'b0;
                endcase
                if (funct == mips_pkg::FN_SLL || funct == mips_pkg::FN_SRL ||
                    funct == mips_pkg::FN_SRA) begin
                    rd_en1   = 1'b0;  // shift amount comes from the word
                    dec_wen  = (rs == '0);
                    imm_data = {{(mips_pkg::DATA_WIDTH-5){1'b0}}, shamt};
                end
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
                rd_en1   = 1'b1;
                dec_wen  = 1'b1;
                imm_data = {{(mips_pkg::DATA_WIDTH-16){1'b0}}, imm};
                case (opcode)
                    mips_pkg::OP_ANDI: dec_op = mips_pkg::ALU_AND;
                    mips_pkg::OP_ORI:  dec_op = mips_pkg::ALU_OR;
                    default:           dec_op = mips_pkg::ALU_XOR;
                endcase
            end
            mips_pkg::OP_LUI: begin
                dec_op   = mips_pkg::ALU_OR;  // both operands carry imm so or gives it back
                dec_wen  = 1'b1;
                imm_data = {imm, {(mips_pkg::DATA_WIDTH-16){1'b0}}};
            end
            mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
                rd_en1   = 1'b1;
                dec_wen  = 1'b1;
                imm_data = {{(mips_pkg::DATA_WIDTH-16){imm[15]}}, imm};
                case (opcode)
                    mips_pkg::OP_SLTI:  dec_op = mips_pkg::ALU_SLT;
                    mips_pkg::OP_SLTIU: dec_op = mips_pkg::ALU_SLTU;
                    default:            dec_op = mips_pkg::ALU_ADD;
                endcase
            end
            default: dec_wen = 1'b0;
        endcase
    end

    // ##############################
    // operand forwarding
    // ##############################

    logic [mips_pkg::DATA_WIDTH-1:0] opnd1;
    logic [mips_pkg::DATA_WIDTH-1:0] opnd2;
    logic                            mov_wen;
    logic                            wreg;

    assign rd_addr1 = rs;
    assign rd_addr2 = rt;

    // the execute result is newest and the one waiting for write-back comes next
    assign opnd1 = !rd_en1                       ? imm_data :
                   (ex_wen && ex_waddr == rs)    ? ex_wdata :
                   (wb_en && wb_addr == rs)      ? wb_data  : rd_data1;
    assign opnd2 = !rd_en2                       ? imm_data :
                   (ex_wen && ex_waddr == rt)    ? ex_wdata :
                   (wb_en && wb_addr == rt)      ? wb_data  : rd_data2;

    assign mov_wen = (funct == mips_pkg::FN_MOVN) ? (opnd2 != '0) : (opnd2 == '0);
    assign wreg    = ((dec_op == mips_pkg::ALU_MOV) ? (dec_wen && mov_wen) : dec_wen) &&
                     (dec_waddr != '0);  // r0 writes die here

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_op   <= mips_pkg::ALU_NOP;
            ex_sel  <= mips_pkg::SEL_NONE;
            ex_wreg <= 1'b0;
        end else begin
            ex_op   <= dec_op;
            ex_sel  <= op_class(dec_op);
            ex_wreg <= wreg;
        end
    end

    always_ff @(posedge clk) begin
        ex_opnd1   <= opnd1;
        ex_opnd2   <= opnd2;
        ex_waddr_d <= dec_waddr;
    end

endmodule

/* rtl/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  logic                                clk,
    input  logic                                rst_n,
    input  mips_pkg::alu_op_e                   ex_op,
    input  mips_pkg::alu_sel_e                  ex_sel,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd1,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd2,
    input  logic                                ex_wreg,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr_d,
    output logic                                ex_wen,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr,
    output logic [mips_pkg::DATA_WIDTH-1:0]     ex_wdata,
    output logic                                res_wen,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] res_waddr,
    output logic [mips_pkg::DATA_WIDTH-1:0]     res_data
);

    logic [mips_pkg::DATA_WIDTH-1:0] logic_res;
    logic [mips_pkg::DATA_WIDTH-1:0] shift_res;
    logic [mips_pkg::DATA_WIDTH-1:0] arith_res;
    logic [mips_pkg::DATA_WIDTH-1:0] move_res;
    logic [4:0]                      shift_amt;

    assign shift_amt = ex_opnd1[4:0];  // shifts move operand 2, amount rides in operand 1

    always_comb begin
        case (ex_op)
            mips_pkg::ALU_AND: logic_res = ex_opnd1 & ex_opnd2;
            mips_pkg::ALU_OR:  logic_res = ex_opnd1 | ex_opnd2;
            mips_pkg::ALU_XOR: logic_res = ex_opnd1 ^ ex_opnd2;
            mips_pkg::ALU_NOR: logic_res = ~(ex_opnd1 | ex_opnd2);
            default:           logic_res = '0;
        endcase
        case (ex_op)
            mips_pkg::ALU_SLL: shift_res = ex_opnd2 << shift_amt;
            mips_pkg::ALU_SRL: shift_res = ex_opnd2 >> shift_amt;
            mips_pkg::ALU_SRA: shift_res = $signed(ex_opnd2) >>> shift_amt;
            default:           shift_res = '0;
        endcase
        case (ex_op)
            mips_pkg::ALU_ADD:  arith_res = ex_opnd1 + ex_opnd2;
            mips_pkg::ALU_SUB:  arith_res = ex_opnd1 - ex_opnd2;
            mips_pkg::ALU_SLT:  arith_res = {{(mips_pkg::DATA_WIDTH-1){1'b0}},
                                             $signed(ex_opnd1) < $signed(ex_opnd2)};
            mips_pkg::ALU_SLTU: arith_res = {{(mips_pkg::DATA_WIDTH-1){1'b0}},
                                             ex_opnd1 < ex_opnd2};
            default:            arith_res = '0;
        endcase
    end

    assign move_res = (ex_op == mips_pkg::ALU_MOV) ? ex_opnd1 : '0;

    // ##############################
    // result select and forward
    // ##############################

    always_comb begin
        case (ex_sel)
            mips_pkg::SEL_LOGIC: ex_wdata = logic_res;
            mips_pkg::SEL_SHIFT: ex_wdata = shift_res;
            mips_pkg::SEL_ARITH: ex_wdata = arith_res;
            mips_pkg::SEL_MOVE:  ex_wdata = move_res;
            default:             ex_wdata = '0;
        endcase
    end

    assign ex_wen   = ex_wreg;
    assign ex_waddr = ex_waddr_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_wen <= 1'b0;
        end else begin
            res_wen <= ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        res_waddr <= ex_waddr;
        res_data  <= ex_wdata;
    end

endmodule

/* rtl/wb_regfile.sv */
`timescale 1ns/1ps

module wb_regfile (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr1,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr2,
    input  logic                                res_wen,
    input  logic [mips_pkg::REG_ADDR_WIDTH-1:0] res_waddr,
    input  logic [mips_pkg::DATA_WIDTH-1:0]     res_data,
    output logic [mips_pkg::DATA_WIDTH-1:0]     rd_data1,
    output logic [mips_pkg::DATA_WIDTH-1:0]     rd_data2,
    output logic                                wb_en,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [mips_pkg::DATA_WIDTH-1:0]     wb_data
);

    localparam int REG_COUNT = 2 ** mips_pkg::REG_ADDR_WIDTH;

    logic [mips_pkg::DATA_WIDTH-1:0] regs [REG_COUNT];

    // the result register is the write-back stage, it lands in the array next edge
    assign wb_en   = res_wen;
    assign wb_addr = res_waddr;
    assign wb_data = res_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;  // decode never lets r0 through
        end
    end

    // ##############################
    // read ports
    // ##############################

    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mips_pkg::INST_WIDTH-1:0]     inst_data,
    output logic                                wb_en,
    output logic [mips_pkg::REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [mips_pkg::DATA_WIDTH-1:0]     wb_data
);

    logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr1;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] rd_addr2;
    logic [mips_pkg::DATA_WIDTH-1:0]     rd_data1;
    logic [mips_pkg::DATA_WIDTH-1:0]     rd_data2;

    // execute forward path
    logic                                ex_wen;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr;
    logic [mips_pkg::DATA_WIDTH-1:0]     ex_wdata;

    // decode/execute register
    mips_pkg::alu_op_e                   ex_op;
    mips_pkg::alu_sel_e                  ex_sel;
    logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd1;
    logic [mips_pkg::DATA_WIDTH-1:0]     ex_opnd2;
    logic                                ex_wreg;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] ex_waddr_d;

    // execute/write-back register
    logic                                res_wen;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] res_waddr;
    logic [mips_pkg::DATA_WIDTH-1:0]     res_data;

    id_decode u_id_decode (
        .clk        (clk),        .rst_n      (rst_n),
        .inst_data  (inst_data),
        .rd_data1   (rd_data1),   .rd_data2   (rd_data2),
        .ex_wen     (ex_wen),     .ex_waddr   (ex_waddr),   .ex_wdata (ex_wdata),
        .wb_en      (wb_en),      .wb_addr    (wb_addr),    .wb_data  (wb_data),
        .rd_addr1   (rd_addr1),   .rd_addr2   (rd_addr2),
        .ex_op      (ex_op),      .ex_sel     (ex_sel),
        .ex_opnd1   (ex_opnd1),   .ex_opnd2   (ex_opnd2),
        .ex_wreg    (ex_wreg),    .ex_waddr_d (ex_waddr_d)
    );

    ex_alu u_ex_alu (
        .clk        (clk),        .rst_n      (rst_n),
        .ex_op      (ex_op),      .ex_sel     (ex_sel),
        .ex_opnd1   (ex_opnd1),   .ex_opnd2   (ex_opnd2),
        .ex_wreg    (ex_wreg),    .ex_waddr_d (ex_waddr_d),
        .ex_wen     (ex_wen),     .ex_waddr   (ex_waddr),   .ex_wdata (ex_wdata),
        .res_wen    (res_wen),    .res_waddr  (res_waddr),  .res_data (res_data)
    );

    wb_regfile u_wb_regfile (
        .clk        (clk),        .rst_n      (rst_n),
        .rd_addr1   (rd_addr1),   .rd_addr2   (rd_addr2),
        .res_wen    (res_wen),    .res_waddr  (res_waddr),  .res_data (res_data),
        .rd_data1   (rd_data1),   .rd_data2   (rd_data2),
        .wb_en      (wb_en),      .wb_addr    (wb_addr),    .wb_data  (wb_data)
    );

endmodule

/* sim/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// ##############################
// instruction encoders
// ##############################

function automatic logic [mips_pkg::INST_WIDTH-1:0] enc_r(
    input mips_pkg::funct_e fn, input logic [4:0] rs, input logic [4:0] rt,
    input logic [4:0] rd, input logic [4:0] sa);
    return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [mips_pkg::INST_WIDTH-1:0] enc_i(
    input mips_pkg::opcode_e op, input logic [4:0] rs, input logic [4:0] rt,
    input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// ##############################
// architectural register model
// ##############################

logic [mips_pkg::DATA_WIDTH-1:0] model_regs [32];

// executes one instruction in program order and returns what it retires
function automatic void model_exec(input logic [31:0] inst, output logic en,
                                   output logic [4:0] addr, output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    a    = model_regs[inst[25:21]];
    b    = model_regs[inst[20:16]];
    simm = {{16{inst[15]}}, inst[15:0]};
    en   = 1'b1;
    addr = inst[20:16];
    data = '0;
    case (inst[31:26])
        mips_pkg::OP_SPECIAL: begin
            addr = inst[15:11];
            case (inst[5:0])
                mips_pkg::FN_SLL:  data = b << inst[10:6];
                mips_pkg::FN_SRL:  data = b >> inst[10:6];
                mips_pkg::FN_SRA:  data = $signed(b) >>> inst[10:6];
                mips_pkg::FN_SLLV: data = b << a[4:0];
                mips_pkg::FN_SRLV: data = b >> a[4:0];
                mips_pkg::FN_SRAV: data = $signed(b) >>> a[4:0];
                mips_pkg::FN_ADD, mips_pkg::FN_ADDU: data = a + b;
                mips_pkg::FN_SUB, mips_pkg::FN_SUBU: data = a - b;
                mips_pkg::FN_AND:  data = a & b;
                mips_pkg::FN_OR:   data = a | b;
                mips_pkg::FN_XOR:  data = a ^ b;
                mips_pkg::FN_NOR:  data = ~(a | b);
                mips_pkg::FN_SLT:  data = {31'b0, $signed(a) < $signed(b)};
                mips_pkg::FN_SLTU: data = {31'b0, a < b};
                mips_pkg::FN_MOVZ: begin
                    data = a;
                    en   = (b == '0);
                end
                mips_pkg::FN_MOVN: begin
                    data = a;
                    en   = (b != '0);
                end
                default: en = 1'b0;  // sync and the dropped hi/lo ops
            endcase
        end
        mips_pkg::OP_ANDI:  data = a & {16'b0, inst[15:0]};
        mips_pkg::OP_ORI:   data = a | {16'b0, inst[15:0]};
        mips_pkg::OP_XORI:  data = a ^ {16'b0, inst[15:0]};
        mips_pkg::OP_LUI:   data = {inst[15:0], 16'b0};
        mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: data = a + simm;
        mips_pkg::OP_SLTI:  data = {31'b0, $signed(a) < $signed(simm)};
        mips_pkg::OP_SLTIU: data = {31'b0, a < simm};
        default: en = 1'b0;
    endcase
    if (addr == '0) begin
        en = 1'b0;
    end
    if (en) begin
        model_regs[addr] = data;
    end
endfunction

`endif

/* sim/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 3;
    localparam int ROUNDS       = 8;
    localparam int TOTAL_STEPS  = 40 + 40 * ROUNDS;  // no round issues more than 40 words
    localparam int WATCHDOG_NS  = (RESET_CYCLES + TOTAL_STEPS) * CLK_PERIOD + 2000;

    logic                                clk;
    logic                                rst_n;
    logic [mips_pkg::INST_WIDTH-1:0]     inst_data;
    logic                                wb_en;
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] wb_addr;
    logic [mips_pkg::DATA_WIDTH-1:0]     wb_data;
    int unsigned                         seed_val;

    // results still in flight with the oldest first
    string                               name_q [$];
    logic                                exp_en_q [$];
    logic [mips_pkg::REG_ADDR_WIDTH-1:0] exp_addr_q [$];
    logic [mips_pkg::DATA_WIDTH-1:0]     exp_data_q [$];

    `include "mips_ref_model.svh"

    mips_core u_mips_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_data (inst_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ##############################
    // compare tasks
    // ##############################

    task automatic check_en(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: test %s, wb_en expected %b, actual %b", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input logic [mips_pkg::REG_ADDR_WIDTH-1:0] exp,
                              input logic [mips_pkg::REG_ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("Error: test %s, wb_addr expected %0d, actual %0d", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [mips_pkg::DATA_WIDTH-1:0] exp,
                              input logic [mips_pkg::DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("Error: test %s, wb_data expected %h, actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_retire();
        string name;
        logic  en;
        name = name_q.pop_front();
        en   = exp_en_q.pop_front();
        check_en(name, en, wb_en);
        if (en) begin
            check_addr(name, exp_addr_q.pop_front(), wb_addr);
            check_data(name, exp_data_q.pop_front(), wb_data);
        end else begin
            void'(exp_addr_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    endtask

    // one word per clock and the word issued two clocks back is on wb_* now
    task automatic issue(input string name, input logic [mips_pkg::INST_WIDTH-1:0] inst);
        logic                                en;
        logic [mips_pkg::REG_ADDR_WIDTH-1:0] addr;
        logic [mips_pkg::DATA_WIDTH-1:0]     data;
        @(posedge clk);
        #DRIVE_DELAY;
        if (name_q.size() == 2) begin
            check_retire();
        end
        inst_data = inst;
        model_exec(inst, en, addr, data);
        name_q.push_back(name);
        exp_en_q.push_back(en);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic finish_checks();
        while (name_q.size() > 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
            inst_data = '0;
            check_retire();
        end
    endtask

    task automatic load_reg(input string name, input logic [4:0] r, input logic [31:0] value);
        issue(name, enc_i(mips_pkg::OP_LUI, 5'd0, r, value[31:16]));
        issue(name, enc_i(mips_pkg::OP_ORI, r, r, value[15:0]));
    endtask

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(31, 1));
    endfunction

    // ##############################
    // directed tests
    // ##############################

    task automatic test_nop();
        check_en("reset", 1'b0, wb_en);
        issue("nop", '0);
        issue("nop", enc_r(mips_pkg::FN_SYNC, 5'd0, 5'd0, 5'd7, 5'd0));
        issue("nop", enc_i(mips_pkg::OP_PREF, 5'd3, 5'd4, 16'h0040));
        issue("nop", {mips_pkg::OP_SPECIAL2, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000010});  // mul
        issue("nop", {6'b000010, 26'h0123456});  // jump is not part of this core
        issue("nop", {mips_pkg::OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'b011000});  // mult
        issue("nop", enc_i(mips_pkg::OP_ORI, 5'd0, 5'd0, 16'hbeef));
        issue("nop", enc_r(mips_pkg::FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
    endtask

    task automatic test_imm();
        logic [4:0]  r;
        logic [15:0] imm;
        repeat (ROUNDS) begin
            r   = rand_reg();
            imm = 16'($urandom());
            issue("imm", enc_i(mips_pkg::OP_ORI, 5'd0, r, imm));
            issue("imm", enc_i(mips_pkg::OP_LUI, 5'd0, r, imm));
            issue("imm", enc_i(mips_pkg::OP_ORI, r, r, 16'($urandom())));
            issue("imm", enc_i(mips_pkg::OP_ANDI, r, rand_reg(), 16'($urandom())));
            issue("imm", enc_i(mips_pkg::OP_XORI, r, r, imm));
        end
    endtask

    task automatic test_fwd();
        mips_pkg::funct_e ops [8];
        ops = '{mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU};
        for (int i = 1; i < 5; i++) begin
            load_reg("fwd", 5'(i), $urandom());
        end
        issue("fwd", enc_r(mips_pkg::FN_ADDU, 5'd1, 5'd2, 5'd5, 5'd0));
        issue("fwd", enc_r(mips_pkg::FN_XOR, 5'd5, 5'd3, 5'd6, 5'd0));  // distance 1
        issue("fwd", enc_r(mips_pkg::FN_OR, 5'd5, 5'd6, 5'd7, 5'd0));   // distance 2 and 1
        issue("fwd", enc_r(mips_pkg::FN_SUBU, 5'd5, 5'd7, 5'd8, 5'd0)); // distance 3
        // a small register window keeps dependences close together
        repeat (ROUNDS * 2) begin
            issue("fwd", enc_r(ops[$urandom_range(7, 0)], 5'($urandom_range(6, 1)),
                               5'($urandom_range(6, 1)), 5'($urandom_range(6, 1)), 5'd0));
        end
    endtask

    task automatic test_shift();
        load_reg("shift", 5'd10, 32'h8000_0000 | $urandom());
        load_reg("shift", 5'd11, 32'h7fff_ffff & $urandom());
        repeat (ROUNDS) begin
            load_reg("shift", 5'd12, $urandom());  // upper bits of the amount must be ignored
            for (int rt = 10; rt < 12; rt++) begin
                issue("shift", enc_r(mips_pkg::FN_SLL, 5'd0, 5'(rt), 5'd13, 5'($urandom())));
                issue("shift", enc_r(mips_pkg::FN_SRL, 5'd0, 5'(rt), 5'd14, 5'($urandom())));
                issue("shift", enc_r(mips_pkg::FN_SRA, 5'd0, 5'(rt), 5'd15, 5'($urandom())));
                issue("shift", enc_r(mips_pkg::FN_SLLV, 5'd12, 5'(rt), 5'd16, 5'd0));
                issue("shift", enc_r(mips_pkg::FN_SRLV, 5'd12, 5'(rt), 5'd17, 5'd0));
                issue("shift", enc_r(mips_pkg::FN_SRAV, 5'd12, 5'(rt), 5'd18, 5'd0));
            end
        end
    endtask

    task automatic test_arith();
        mips_pkg::funct_e  rops [6];
        mips_pkg::opcode_e iops [4];
        rops = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
                 mips_pkg::FN_SUBU, mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
        iops = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU};
        load_reg("arith", 5'd20, 32'h7fff_ffff);
        load_reg("arith", 5'd21, 32'h8000_0000);
        issue("arith", enc_r(mips_pkg::FN_ADD, 5'd20, 5'd20, 5'd22, 5'd0));
        issue("arith", enc_i(mips_pkg::OP_ADDI, 5'd20, 5'd23, 16'h0001));  // wraps to min
        issue("arith", enc_r(mips_pkg::FN_SUB, 5'd21, 5'd20, 5'd24, 5'd0));
        issue("arith", enc_i(mips_pkg::OP_ADDIU, 5'd21, 5'd25, 16'hffff));
        issue("arith", enc_r(mips_pkg::FN_SLT, 5'd21, 5'd20, 5'd26, 5'd0));
        issue("arith", enc_r(mips_pkg::FN_SLTU, 5'd21, 5'd20, 5'd27, 5'd0));
        issue("arith", enc_i(mips_pkg::OP_SLTI, 5'd21, 5'd28, 16'hffff));
        issue("arith", enc_i(mips_pkg::OP_SLTIU, 5'd20, 5'd29, 16'hffff));
        repeat (ROUNDS) begin
            load_reg("arith", 5'd20, $urandom());
            load_reg("arith", 5'd21, $urandom());
            repeat (3) begin
                issue("arith", enc_r(rops[$urandom_range(5, 0)], 5'd20, 5'd21, rand_reg(), 5'd0));
                issue("arith", enc_i(iops[$urandom_range(3, 0)], 5'd21, rand_reg(),
                                     16'($urandom())));
            end
        end
    endtask

    task automatic test_move();
        logic [15:0] imm;
        for (int i = 0; i < ROUNDS; i++) begin
            load_reg("move", 5'd1, $urandom());
            imm = (i % 2 == 1) ? (16'($urandom()) | 16'h0001) : 16'h0000;  // odd rounds set rt
            issue("move", enc_i(mips_pkg::OP_ORI, 5'd0, 5'd9, imm));  // rt made right before
            issue("move", enc_r(mips_pkg::FN_MOVN, 5'd1, 5'd9, 5'd10, 5'd0));
            issue("move", enc_r(mips_pkg::FN_MOVZ, 5'd1, 5'd9, 5'd11, 5'd0));
            issue("move", enc_r(mips_pkg::FN_ADDU, 5'd10, 5'd11, 5'd12, 5'd0));
        end
    endtask

    // ##############################
    // run control
    // ##############################

    initial begin
        seed_val  = $urandom(5846);
        clk       = 1'b0;
        rst_n     = 1'b0;
        inst_data = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        test_nop();
        test_imm();
        test_fwd();
        test_shift();
        test_arith();
        test_move();
        finish_checks();
        $display("Simulation completed successfully");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

/* project.f */
+incdir+sim
rtl/mips_pkg.sv
rtl/id_decode.sv
rtl/ex_alu.sv
rtl/wb_regfile.sv
rtl/mips_core.sv
sim/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/id_decode.sv
  - rtl/ex_alu.sv
  - rtl/wb_regfile.sv
  - rtl/mips_core.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_core.sv
